//--- design/qpu_cfg_pkg.sv
//////////////////////////////
// Datapath configuration
// Widths and default sizes of the registers, timer and event queue
//////////////////////////////

`default_nettype none

package qpu_cfg_pkg;

  // Classical datapath
  localparam int XLEN    = 32;  // Register width
  localparam int RF_NUM  = 16;  // Register count
  localparam int RFIDX_W = 4;

  //////////////////////////////
  // Timing side
  localparam int TIME_WIDTH      = 16;
  localparam int EVENT_NUM       = 4;   // Event channels
  localparam int EDATA_W         = 8;
  localparam int QUEUE_DEPTH_DEF = 8;   // Default event queue depth

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [RFIDX_W-1:0]    rfidx_t;
  typedef logic [TIME_WIDTH-1:0] time_t;
  typedef logic [EVENT_NUM-1:0]  evmask_t;  // One bit per channel
  typedef logic [EDATA_W-1:0]    edata_t;

endpackage

`default_nettype wire

//--- design/qpu_event_queue.sv
//////////////////////////////
// Event queue
// Circular FIFO of timed events, sticky overflow
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_event_queue
  import qpu_cfg_pkg::*;
#(
  parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_push,
  input  time_t   i_push_time,
  input  evmask_t i_push_mask,
  input  edata_t  i_push_data,
  input  logic    i_pop,
  output logic    o_head_valid,
  output time_t   o_head_time,
  output evmask_t o_head_mask,
  output edata_t  o_head_data,
  output logic    o_overflow
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

  time_t   time_mem [QUEUE_DEPTH];
  evmask_t mask_mem [QUEUE_DEPTH];
  edata_t  data_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             ovf_q;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == LAST) ? '0 : ptr + 1'b1;  // Wraps for any depth
  endfunction

  assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
  assign push_ok = i_push & ~full;
  assign pop_ok  = i_pop & (count_q != '0);

  always_ff @(posedge clk) begin
    if (push_ok) begin
      time_mem[wr_ptr_q] <= i_push_time;
      mask_mem[wr_ptr_q] <= i_push_mask;
      data_mem[wr_ptr_q] <= i_push_data;
    end
  end

  //////////////////////////////
  // Pointers, count, overflow
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
      if (i_push && full) ovf_q <= 1'b1;  // Dropped push
    end
  end

  assign o_head_valid = (count_q != '0);
  assign o_head_time  = time_mem[rd_ptr_q];
  assign o_head_mask  = mask_mem[rd_ptr_q];
  assign o_head_data  = data_mem[rd_ptr_q];
  assign o_overflow   = ovf_q;

  // Trigger only pops a valid head
  a_no_empty_pop: assert property (@(posedge clk) disable iff (i_reset) i_pop |-> count_q != '0);
  a_count_max: assert property (@(posedge clk) disable iff (i_reset)
    count_q <= CNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- design/qpu_event_trigger.sv
//////////////////////////////
// Event trigger
// Timer, release check and registered event outputs
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_event_trigger
  import qpu_cfg_pkg::*;
(
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_trigger,
  input  logic    i_head_valid,
  input  time_t   i_head_time,
  input  evmask_t i_head_mask,
  input  edata_t  i_head_data,
  output logic    o_pop,
  output evmask_t o_event_valid,
  output edata_t  o_event_data
);

  localparam time_t TIMER_MAX = '1;

  logic    running_q;
  time_t   timer_q;
  logic    due;
  evmask_t ev_valid_q;
  edata_t  ev_data_q;

  // Trigger restarts from zero, timer saturates
  always_ff @(posedge clk) begin
    if (i_reset) begin
      running_q <= 1'b0;
      timer_q   <= '0;
    end else if (i_trigger) begin
      running_q <= 1'b1;
      timer_q   <= '0;
    end else if (running_q && (timer_q != TIMER_MAX)) begin
      timer_q <= timer_q + 1'b1;
    end
  end

  assign due   = running_q & i_head_valid & (timer_q >= i_head_time);
  assign o_pop = due;

  //////////////////////////////
  // Released event, one cycle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ev_valid_q <= '0;
    end else begin
      ev_valid_q <= due ? i_head_mask : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (due) ev_data_q <= i_head_data;
  end

  assign o_event_valid = ev_valid_q;
  assign o_event_data  = ev_data_q;

  a_quiet_after_reset: assert property (@(posedge clk) i_reset |=> o_event_valid == '0);

endmodule

`default_nettype wire

//--- design/qpu_exu.sv
//////////////////////////////
// Execute stage top
// Decode, register file, ALU, event queue and trigger
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_exu
  import qpu_cfg_pkg::*;
  import qpu_isa_pkg::*;
#(
  parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_valid,
  input  instr_u  i_ir,
  input  logic    i_trigger,
  output evmask_t o_event_valid,
  output edata_t  o_event_data,
  output logic    o_overflow
);

  // Decode to ALU
  logic    dec_valid;
  opcode_t dec_op;
  rfidx_t  dec_rd;
  rfidx_t  dec_rs1;
  rfidx_t  dec_rs2;
  time_t   dec_imm;
  evmask_t dec_mask;
  edata_t  dec_edata;

  // Register file ports
  rfidx_t rf_rs1_idx;
  rfidx_t rf_rs2_idx;
  xlen_t  rf_rs1_data;
  xlen_t  rf_rs2_data;
  logic   rf_wr_en;
  rfidx_t rf_wr_idx;
  xlen_t  rf_wr_data;

  // Queue side
  logic    push;
  time_t   push_time;
  evmask_t push_mask;
  edata_t  push_data;
  logic    pop;
  logic    head_valid;
  time_t   head_time;
  evmask_t head_mask;
  edata_t  head_data;

  //////////////////////////////
  // Processing side
  qpu_exu_decode u_decode (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_ir    (i_ir),
    .o_valid (dec_valid),
    .o_op    (dec_op),
    .o_rd    (dec_rd),
    .o_rs1   (dec_rs1),
    .o_rs2   (dec_rs2),
    .o_imm   (dec_imm),
    .o_mask  (dec_mask),
    .o_edata (dec_edata)
  );

  qpu_exu_regfile u_regfile (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rs1_idx  (rf_rs1_idx),
    .i_rs2_idx  (rf_rs2_idx),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data),
    .i_wr_en    (rf_wr_en),
    .i_wr_idx   (rf_wr_idx),
    .i_wr_data  (rf_wr_data)
  );

  qpu_exu_alu u_alu (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (dec_valid),
    .i_op        (dec_op),
    .i_rd        (dec_rd),
    .i_rs1       (dec_rs1),
    .i_rs2       (dec_rs2),
    .i_imm       (dec_imm),
    .i_mask      (dec_mask),
    .i_edata     (dec_edata),
    .i_rs1_data  (rf_rs1_data),
    .i_rs2_data  (rf_rs2_data),
    .o_rs1_idx   (rf_rs1_idx),
    .o_rs2_idx   (rf_rs2_idx),
    .o_wr_en     (rf_wr_en),
    .o_wr_idx    (rf_wr_idx),
    .o_wr_data   (rf_wr_data),
    .o_push      (push),
    .o_push_time (push_time),
    .o_push_mask (push_mask),
    .o_push_data (push_data)
  );

  //////////////////////////////
  // Output side
  qpu_event_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_push       (push),
    .i_push_time  (push_time),
    .i_push_mask  (push_mask),
    .i_push_data  (push_data),
    .i_pop        (pop),
    .o_head_valid (head_valid),
    .o_head_time  (head_time),
    .o_head_mask  (head_mask),
    .o_head_data  (head_data),
    .o_overflow   (o_overflow)
  );

  qpu_event_trigger u_trigger (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_trigger     (i_trigger),
    .i_head_valid  (head_valid),
    .i_head_time   (head_time),
    .i_head_mask   (head_mask),
    .i_head_data   (head_data),
    .o_pop         (pop),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data)
  );

endmodule

`default_nettype wire

//--- design/qpu_exu_alu.sv
//////////////////////////////
// Execute stage
// Arithmetic, time register and event push
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_exu_alu
  import qpu_cfg_pkg::*;
  import qpu_isa_pkg::*;
(
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_valid,
  input  opcode_t i_op,
  input  rfidx_t  i_rd,
  input  rfidx_t  i_rs1,
  input  rfidx_t  i_rs2,
  input  time_t   i_imm,
  input  evmask_t i_mask,
  input  edata_t  i_edata,
  input  xlen_t   i_rs1_data,
  input  xlen_t   i_rs2_data,
  output rfidx_t  o_rs1_idx,
  output rfidx_t  o_rs2_idx,
  output logic    o_wr_en,
  output rfidx_t  o_wr_idx,
  output xlen_t   o_wr_data,
  output logic    o_push,
  output time_t   o_push_time,
  output evmask_t o_push_mask,
  output edata_t  o_push_data
);

  time_t time_q;     // Accumulated event time
  time_t time_next;
  logic  is_arith;
  logic  is_event;
  xlen_t result;

  assign is_arith  = (i_op == OP_ADD) || (i_op == OP_SUB) || (i_op == OP_ADDI);
  assign is_event  = (i_op == OP_QEVT) || (i_op == OP_QEVR);
  assign time_next = time_q + i_imm;

  always_comb begin
    case (i_op)
      OP_ADD:  result = i_rs1_data + i_rs2_data;
      OP_SUB:  result = i_rs1_data - i_rs2_data;
      OP_ADDI: result = i_rs1_data + {{(XLEN-TIME_WIDTH){1'b0}}, i_imm};  // Zero-extended
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      time_q <= '0;
    end else if (i_valid && is_event) begin
      time_q <= time_next;
    end
  end

  assign o_rs1_idx = i_rs1;
  assign o_rs2_idx = i_rs2;

  // Write lands at the end of this cycle
  assign o_wr_en   = i_valid & is_arith;
  assign o_wr_idx  = i_rd;
  assign o_wr_data = result;

  //////////////////////////////
  // Event push carries the new time
  assign o_push      = i_valid & is_event;
  assign o_push_time = time_next;
  assign o_push_mask = i_mask;
  assign o_push_data = (i_op == OP_QEVR) ? i_rs1_data[EDATA_W-1:0] : i_edata;

endmodule

`default_nettype wire

//--- design/qpu_exu_decode.sv
//////////////////////////////
// Execute stage decode
// Registers the instruction and splits it into fields
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_exu_decode
  import qpu_cfg_pkg::*;
  import qpu_isa_pkg::*;
(
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_valid,  // One-cycle strobe
  input  instr_u  i_ir,
  output logic    o_valid,
  output opcode_t o_op,
  output rfidx_t  o_rd,
  output rfidx_t  o_rs1,
  output rfidx_t  o_rs2,
  output time_t   o_imm,
  output evmask_t o_mask,
  output edata_t  o_edata
);

  logic   valid_q;
  instr_u ir_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  // Word only loads on a strobe
  always_ff @(posedge clk) begin
    if (i_valid) begin
      ir_q <= i_ir;
    end
  end

  always_comb begin
    case (ir_q.cls.op)
      OP_ADD, OP_SUB, OP_ADDI, OP_QEVT, OP_QEVR: o_op = ir_q.cls.op;
      default: o_op = OP_NOP;  // Unknown opcode
    endcase
  end

  assign o_valid = valid_q;
  assign o_rd    = ir_q.cls.rd;
  assign o_rs1   = ir_q.cls.rs1;
  assign o_rs2   = ir_q.cls.rs2;
  assign o_imm   = ir_q.cls.imm;    // Also the event delta
  assign o_mask  = ir_q.tim.mask;
  assign o_edata = ir_q.tim.edata;

  // Strobe must be clean once out of reset
  a_valid_known: assert property (@(posedge clk) disable iff (i_reset) !$isunknown(i_valid));

endmodule

`default_nettype wire

//--- design/qpu_exu_regfile.sv
//////////////////////////////
// Classical register file
// Two combinational reads, one write, r0 hard zero
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qpu_exu_regfile
  import qpu_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  input  rfidx_t i_rs1_idx,
  input  rfidx_t i_rs2_idx,
  output xlen_t  o_rs1_data,
  output xlen_t  o_rs2_data,
  input  logic   i_wr_en,
  input  rfidx_t i_wr_idx,
  input  xlen_t  i_wr_data
);

  xlen_t rf_q [RF_NUM];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wr_en && (i_wr_idx != '0)) begin
      rf_q[i_wr_idx] <= i_wr_data;  // r0 never written
    end
  end

  //////////////////////////////
  // Read ports
  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : rf_q[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : rf_q[i_rs2_idx];

endmodule

`default_nettype wire

//--- design/qpu_isa_pkg.sv
//////////////////////////////
// Instruction set
// Opcodes and the two views of an instruction word
//////////////////////////////

`default_nettype none

package qpu_isa_pkg;

  import qpu_cfg_pkg::*;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_ADDI = 4'd3,
    OP_QEVT = 4'd4,  // Advance time, queue event
    OP_QEVR = 4'd5   // Same, data from rs1
  } opcode_t;

  //////////////////////////////
  // Classical view
  typedef struct packed {
    opcode_t op;   // 31:28
    rfidx_t  rd;   // 27:24
    rfidx_t  rs1;  // 23:20
    rfidx_t  rs2;  // 19:16
    time_t   imm;  // 15:0
  } instr_cls_t;

  //////////////////////////////
  // Timing view
  typedef struct packed {
    opcode_t op;     // 31:28
    evmask_t mask;   // 27:24
    edata_t  edata;  // 23:16
    time_t   delta;  // 15:0
  } instr_tim_t;

  // QEVR needs both at once
  // rs1 from the classical side, mask and delta from the timing side
  typedef union packed {
    instr_cls_t cls;
    instr_tim_t tim;
  } instr_u;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_qpu_exu -f tb.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- tb.f
design/qpu_cfg_pkg.sv
design/qpu_isa_pkg.sv
design/qpu_exu_decode.sv
design/qpu_exu_regfile.sv
design/qpu_exu_alu.sv
design/qpu_event_queue.sv
design/qpu_event_trigger.sv
design/qpu_exu.sv
verif/tb_qpu_exu.sv

//--- verif/tb_qpu_exu.sv
//////////////////////////////
// Execute stage testbench
// Directed tests against a model of registers, time and events
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_qpu_exu
  import qpu_cfg_pkg::*;
  import qpu_isa_pkg::*;
();

  localparam int QDEPTH = 4;

  typedef struct packed {
    evmask_t mask;
    edata_t  data;
    time_t   t;      // Accumulated time of the event
  } exp_ev_t;

  logic    clk;
  logic    i_reset;
  logic    i_valid;
  instr_u  i_ir;
  logic    i_trigger;
  evmask_t o_event_valid;
  edata_t  o_event_data;
  logic    o_overflow;

  int          cyc;       // Rising edges seen so far
  int          trig_cyc;  // Edge that sampled the last trigger
  int          errors;
  int          n_checks;
  logic [31:0] rng;

  // Model state
  xlen_t   model_rf [RF_NUM];
  time_t   model_time;
  logic    model_ovf;
  exp_ev_t exp_q [$];

  qpu_exu #(
    .QUEUE_DEPTH (QDEPTH)
  ) u_dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_ir          (i_ir),
    .i_trigger     (i_trigger),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data),
    .o_overflow    (o_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////
  // Helpers
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic instr_u enc_cls(input opcode_t op, input rfidx_t rd, input rfidx_t rs1,
                                     input rfidx_t rs2, input time_t imm);
    instr_u w;
    w.cls.op  = op;
    w.cls.rd  = rd;
    w.cls.rs1 = rs1;
    w.cls.rs2 = rs2;
    w.cls.imm = imm;
    return w;
  endfunction

  function automatic instr_u enc_qevt(input evmask_t mask, input edata_t data, input time_t delta);
    instr_u w;
    w.tim.op    = OP_QEVT;
    w.tim.mask  = mask;
    w.tim.edata = data;
    w.tim.delta = delta;
    return w;
  endfunction

  function automatic instr_u enc_qevr(input evmask_t mask, input rfidx_t rs1, input time_t delta);
    instr_u w;
    w.tim.op    = OP_QEVR;
    w.tim.mask  = mask;
    w.tim.edata = '0;
    w.tim.delta = delta;
    w.cls.rs1   = rs1;  // Overlaps the upper edata nibble
    return w;
  endfunction

  // Reference behavior of one instruction
  task automatic model_exec(input instr_u w);
    xlen_t   res;
    exp_ev_t e;
    res = '0;
    case (w.cls.op)
      OP_ADD:  res = model_rf[w.cls.rs1] + model_rf[w.cls.rs2];
      OP_SUB:  res = model_rf[w.cls.rs1] - model_rf[w.cls.rs2];
      OP_ADDI: res = model_rf[w.cls.rs1] + xlen_t'(w.cls.imm);
      default: res = '0;
    endcase
    if ((w.cls.op == OP_ADD || w.cls.op == OP_SUB || w.cls.op == OP_ADDI) && w.cls.rd != '0)
      model_rf[w.cls.rd] = res;
    if (w.cls.op == OP_QEVT || w.cls.op == OP_QEVR) begin
      model_time = model_time + w.tim.delta;
      e.mask = w.tim.mask;
      e.data = (w.cls.op == OP_QEVR) ? model_rf[w.cls.rs1][EDATA_W-1:0] : w.tim.edata;
      e.t    = model_time;
      if (exp_q.size() >= QDEPTH) model_ovf = 1'b1;  // Full queue drops it
      else exp_q.push_back(e);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    i_reset   <= 1'b1;
    i_valid   <= 1'b0;
    i_trigger <= 1'b0;
    repeat (10) @(posedge clk);
    i_reset <= 1'b0;
    for (int i = 0; i < RF_NUM; i++) model_rf[i] = '0;
    model_time = '0;
    model_ovf  = 1'b0;
    exp_q.delete();
  endtask

  task automatic send_instr(input instr_u w);
    @(posedge clk);
    i_valid <= 1'b1;
    i_ir    <= w;
    model_exec(w);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      i_valid <= 1'b0;
    end
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    i_trigger <= 1'b1;
    @(posedge clk);
    i_trigger <= 1'b0;
    @(negedge clk);
    trig_cyc = cyc;
  endtask

  //////////////////////////////
  // Compare tasks
  task automatic check_mask(input string name, input evmask_t got, input evmask_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_edata(input string name, input edata_t got, input edata_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Bounded wait for a nonzero event mask
  task automatic wait_event(input int limit, output logic found, output int at_cyc,
                            output evmask_t mask, output edata_t data);
    int n;
    found  = 1'b0;
    at_cyc = 0;
    mask   = '0;
    data   = '0;
    n      = 0;
    while (!found && n < limit) begin
      @(negedge clk);
      n++;
      if (o_event_valid != '0) begin
        found  = 1'b1;
        at_cyc = cyc;
        mask   = o_event_valid;
        data   = o_event_data;
      end
    end
  endtask

  task automatic expect_event(input int limit, output int at_cyc);
    exp_ev_t e;
    logic    found;
    evmask_t m;
    edata_t  d;
    at_cyc = 0;
    if (exp_q.size() == 0) begin
      errors++;
      $display("No expected event left in the model at %0t", $time);
      return;
    end
    e = exp_q.pop_front();
    wait_event(limit, found, at_cyc, m, d);
    if (!found) begin
      errors++;
      $display("Timed out at %0t waiting for the event due at time %0d", $time, e.t);
    end else begin
      check_mask("o_event_valid", m, e.mask);
      check_edata("o_event_data", d, e.data);
      n_checks++;
      if (at_cyc < trig_cyc + int'(e.t) + 1) begin
        errors++;
        $display("Event for time %0d released too early at %0t, %0d cycles after the trigger",
                 e.t, $time, at_cyc - trig_cyc);
      end
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      check_mask("o_event_valid", o_event_valid, '0);
    end
  endtask

  //////////////////////////////
  // Tests
  task automatic test_reset();
    reset_dut();
    repeat (20) begin
      @(negedge clk);
      check_mask("o_event_valid", o_event_valid, '0);
      check_flag("o_overflow", o_overflow, 1'b0);
    end
  endtask

  task automatic test_arith();
    opcode_t op;
    rfidx_t  rd;
    int      c;
    reset_dut();
    for (int r = 1; r < RF_NUM; r++) begin  // Seed every register
      rng = xorshift(rng);
      send_instr(enc_cls(OP_ADDI, rfidx_t'(r), rng[23:20], '0, rng[15:0]));
    end
    for (int i = 0; i < 30; i++) begin
      rng = xorshift(rng);
      op = (rng[1:0] == 2'd0) ? OP_ADD : (rng[1:0] == 2'd1) ? OP_SUB : OP_ADDI;
      rd = (rng[10:8] == 3'd0) ? rfidx_t'(0) : rfidx_t'(32'd1 + rng % 32'd15);
      send_instr(enc_cls(op, rd, rng[23:20], rng[27:24], rng[31:16]));
      if (i == 12) send_instr(enc_cls(opcode_t'(4'hA), 4'd3, 4'd3, 4'd3, 16'h1234));
    end
    idle_cycles(3);
    pulse_trigger();
    for (int r = 0; r < RF_NUM; r++) begin
      send_instr(enc_qevr(evmask_t'(r % 15 + 1), rfidx_t'(r), '0));
      idle_cycles(3);
      expect_event(20, c);
    end
  endtask

  task automatic test_timing();
    int c;
    reset_dut();
    send_instr(enc_qevt(4'h1, 8'hA5, 16'd5));
    send_instr(enc_qevt(4'h2, 8'h3C, 16'd3));
    send_instr(enc_qevt(4'h8, 8'h7E, 16'd10));
    idle_cycles(3);
    pulse_trigger();
    repeat (3) expect_event(40, c);
  endtask

  task automatic test_same_time();
    int c [4];
    reset_dut();
    send_instr(enc_qevt(4'h1, 8'h11, 16'd2));
    send_instr(enc_qevt(4'h2, 8'h22, 16'd0));
    send_instr(enc_qevt(4'h4, 8'h33, 16'd0));
    send_instr(enc_qevt(4'h8, 8'h44, 16'd0));
    idle_cycles(3);
    pulse_trigger();
    for (int i = 0; i < 4; i++) expect_event(20, c[i]);
    for (int i = 1; i < 4; i++) begin
      n_checks++;
      if (c[i] != c[i-1] + 1) begin
        errors++;
        $display("Same-time event %0d was not released on the cycle after the one before it", i);
      end
    end
  endtask

  task automatic test_overflow();
    int c;
    reset_dut();
    for (int i = 0; i < 6; i++) begin
      send_instr(enc_qevt(evmask_t'(i % 4 + 1), edata_t'(8'h50 + i), 16'd1));
    end
    idle_cycles(3);
    @(negedge clk);
    check_flag("o_overflow", o_overflow, model_ovf);
    pulse_trigger();
    repeat (QDEPTH) expect_event(30, c);
    expect_quiet(30);  // Dropped pushes never show up
    check_flag("o_overflow", o_overflow, 1'b1);
  endtask

  task automatic test_retrigger();
    int c;
    reset_dut();
    pulse_trigger();
    idle_cycles(40);
    send_instr(enc_qevt(4'h4, 8'h9A, 16'd3));  // Late for a timer near 40
    idle_cycles(3);
    expect_event(20, c);
    pulse_trigger();
    send_instr(enc_qevt(4'h2, 8'hC3, 16'd25));
    idle_cycles(3);
    expect_event(60, c);
  endtask

  //////////////////////////////
  // Main sequence
  initial begin
    i_reset   = 1'b1;
    i_valid   = 1'b0;
    i_ir      = '0;
    i_trigger = 1'b0;
    cyc       = 0;
    trig_cyc  = 0;
    errors    = 0;
    n_checks  = 0;
    rng       = 32'd91;
    test_reset();
    test_arith();
    test_timing();
    test_same_time();
    test_overflow();
    test_retrigger();
    $display("Checks run: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
